// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_xbar_bridge
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
FILELIST  ?= files.f
VFLAGS    ?= --binary --timing --assert

SRCS := $(wildcard hdl/*.sv) $(wildcard testbench/*.sv)
BIN  := $(BUILD_DIR)/$(TOP)

.PHONY: all build run clean

all: run

build: $(BIN)

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o $(TOP)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	grep -q "TEST PASS" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== files.f ====
hdl/xbar_cfg_pkg.sv
hdl/xbar_bus_pkg.sv
hdl/master_port.sv
hdl/slave_arbiter.sv
hdl/xbar_bridge.sv
testbench/tb_xbar_assertions.sv
testbench/tb_checker.sv
testbench/tb_xbar_bridge.sv

// ==== hdl/master_port.sv ====
// Per-master port of the bridge that decodes the address, steers the request and picks responses
`timescale 1ns/1ns

module master_port
#(
    parameter int N_MASTER   = 4,
    parameter int N_SLAVE    = 3,
    parameter int MASTER_IDX = 0
)
(
    // Master request side
    input  logic                                      req_i,
    input  xbar_cfg_pkg::addr_t                       addr_i,
    output logic                                      gnt_o,

    // One address window per slave
    input  xbar_cfg_pkg::addr_t [N_SLAVE-1:0]         start_addr_i,
    input  xbar_cfg_pkg::addr_t [N_SLAVE-1:0]         end_addr_i,

    // Toward the slave arbiters
    output logic [N_SLAVE-1:0]                        dest_req_o,
    input  logic [N_SLAVE-1:0]                        dest_gnt_i,

    // Responses from all slaves
    input  logic [N_SLAVE-1:0]                        slv_r_valid_i,
    input  logic [N_SLAVE-1:0][N_MASTER-1:0]          slv_r_id_i,
    input  xbar_bus_pkg::resp_payload_t [N_SLAVE-1:0] slv_r_payload_i,

    // Response back to the master
    output logic                                      r_valid_o,
    output xbar_bus_pkg::resp_payload_t               r_payload_o
);

    logic [N_SLAVE-1:0] dest_oh;    // Address match per slave
    logic [N_SLAVE-1:0] resp_hit;   // Valid response tagged with our ID

    // Range match, windows are half open and never overlap
    always_comb
    begin
        dest_oh = '0;
        for (int s = 0; s < N_SLAVE; s++)
        begin
            if ((addr_i >= start_addr_i[s]) && (addr_i < end_addr_i[s]))
            begin
                dest_oh[s] = 1'b1;
            end
        end
    end

    assign dest_req_o = req_i ? dest_oh : '0;   // Unmapped address requests nothing
    assign gnt_o      = |dest_gnt_i;            // Only the addressed slave can grant

    // Back-route by the one-hot ID bit of this master
    always_comb
    begin
        for (int s = 0; s < N_SLAVE; s++)
        begin
            resp_hit[s] = slv_r_valid_i[s] & slv_r_id_i[s][MASTER_IDX];
        end
    end

    assign r_valid_o = |resp_hit;

    // At most one slave answers a given master per cycle
    always_comb
    begin
        r_payload_o = '0;
        for (int s = 0; s < N_SLAVE; s++)
        begin
            if (resp_hit[s])
            begin
                r_payload_o = slv_r_payload_i[s];
            end
        end
    end

endmodule

// ==== hdl/slave_arbiter.sv ====
// Round-robin arbiter in front of one memory slave, forwards the winning request with its ID
`timescale 1ns/1ns

module slave_arbiter
#(
    parameter int N_MASTER = 4
)
(
    input  logic                                     clk,
    input  logic                                     rst_i,

    // From the master ports
    input  logic [N_MASTER-1:0]                      mst_req_i,
    input  xbar_bus_pkg::req_payload_t [N_MASTER-1:0] mst_payload_i,
    output logic [N_MASTER-1:0]                      mst_gnt_o,

    // Toward the memory slave
    output logic                                     req_o,
    output xbar_bus_pkg::req_payload_t               payload_o,
    output logic [N_MASTER-1:0]                      id_o,
    input  logic                                     gnt_i
);

    localparam int PTR_W = (N_MASTER > 1) ? $clog2(N_MASTER) : 1;

    typedef logic [PTR_W-1:0] ptr_t;   // Master index

    ptr_t                ptr_q;        // First master to look at
    ptr_t                win_idx;      // Selected master
    ptr_t                ptr_next;
    logic                found;
    logic [N_MASTER-1:0] win_oh;

    // Search from the pointer and wrap around
    always_comb
    begin
        found   = 1'b0;
        win_idx = ptr_q;
        for (int i = 0; i < N_MASTER; i++)
        begin
            if (!found && mst_req_i[(int'(ptr_q) + i) % N_MASTER])
            begin
                found   = 1'b1;
                win_idx = ptr_t'((int'(ptr_q) + i) % N_MASTER);
            end
        end
    end

    always_comb
    begin
        win_oh          = '0;
        win_oh[win_idx] = found;
    end

    assign req_o     = found;
    assign payload_o = mst_payload_i[win_idx];
    assign id_o      = win_oh;                        // One-hot ID returned with the response
    assign mst_gnt_o = win_oh & {N_MASTER{gnt_i}};    // Grant goes to the winner only

    // Master after the winner, with wrap
    assign ptr_next = (int'(win_idx) == N_MASTER - 1) ? '0 : ptr_t'(win_idx + 1'b1);

    // Pointer holds under back-pressure so the winner stays stable
    always_ff @(posedge clk)
    begin
        if (rst_i)
        begin
            ptr_q <= '0;
        end
        else if (req_o && gnt_i)
        begin
            ptr_q <= ptr_next;
        end
    end

endmodule

// ==== hdl/xbar_bridge.sv ====
// Top of the address-decoded bridge, connects master ports and slave arbiters in a full mesh
`timescale 1ns/1ns

module xbar_bridge
#(
    parameter int N_MASTER = 4,    // Also the width of the one-hot ID
    parameter int N_SLAVE  = 3
)
(
    input  logic                                       clk,
    input  logic                                       rst_i,

    // Master request side
    input  logic [N_MASTER-1:0]                        req_i,
    input  xbar_bus_pkg::req_payload_t [N_MASTER-1:0]  payload_i,
    output logic [N_MASTER-1:0]                        gnt_o,

    // Master response side
    output logic [N_MASTER-1:0]                        r_valid_o,
    output xbar_bus_pkg::resp_payload_t [N_MASTER-1:0] r_payload_o,

    // Slave request side
    output logic [N_SLAVE-1:0]                         req_o,
    output xbar_bus_pkg::req_payload_t [N_SLAVE-1:0]   payload_o,
    output logic [N_SLAVE-1:0][N_MASTER-1:0]           id_o,
    input  logic [N_SLAVE-1:0]                         gnt_i,

    // Slave response side
    input  logic [N_SLAVE-1:0]                         r_valid_i,
    input  logic [N_SLAVE-1:0][N_MASTER-1:0]           r_id_i,
    input  xbar_bus_pkg::resp_payload_t [N_SLAVE-1:0]  r_payload_i,

    // Address window of each slave
    input  xbar_cfg_pkg::addr_t [N_SLAVE-1:0]          start_addr_i,
    input  xbar_cfg_pkg::addr_t [N_SLAVE-1:0]          end_addr_i
);

    // Master-major view
    logic [N_MASTER-1:0][N_SLAVE-1:0] mst_dest_req;
    logic [N_MASTER-1:0][N_SLAVE-1:0] mst_dest_gnt;

    // Slave-major view
    logic [N_SLAVE-1:0][N_MASTER-1:0] slv_mst_req;
    logic [N_SLAVE-1:0][N_MASTER-1:0] slv_mst_gnt;

    genvar m, s;

    generate
        for (m = 0; m < N_MASTER; m++)
        begin : g_master
            for (s = 0; s < N_SLAVE; s++)
            begin : g_transpose
                assign slv_mst_req[s][m]  = mst_dest_req[m][s];
                assign mst_dest_gnt[m][s] = slv_mst_gnt[s][m];
            end

            master_port
            #(
                .N_MASTER   ( N_MASTER ),
                .N_SLAVE    ( N_SLAVE  ),
                .MASTER_IDX ( m        )
            )
            i_master_port
            (
                .req_i           ( req_i[m]          ),
                .addr_i          ( payload_i[m].addr ),
                .gnt_o           ( gnt_o[m]          ),
                .start_addr_i    ( start_addr_i      ),
                .end_addr_i      ( end_addr_i        ),
                .dest_req_o      ( mst_dest_req[m]   ),
                .dest_gnt_i      ( mst_dest_gnt[m]   ),
                .slv_r_valid_i   ( r_valid_i         ),
                .slv_r_id_i      ( r_id_i            ),
                .slv_r_payload_i ( r_payload_i       ),
                .r_valid_o       ( r_valid_o[m]      ),
                .r_payload_o     ( r_payload_o[m]    )
            );
        end

        for (s = 0; s < N_SLAVE; s++)
        begin : g_slave
            slave_arbiter
            #(
                .N_MASTER ( N_MASTER )
            )
            i_slave_arbiter
            (
                .clk           ( clk            ),
                .rst_i         ( rst_i          ),
                .mst_req_i     ( slv_mst_req[s] ),
                .mst_payload_i ( payload_i      ),  // Every arbiter sees all payloads
                .mst_gnt_o     ( slv_mst_gnt[s] ),
                .req_o         ( req_o[s]       ),
                .payload_o     ( payload_o[s]   ),
                .id_o          ( id_o[s]        ),
                .gnt_i         ( gnt_i[s]       )
            );
        end
    endgenerate

endmodule

// ==== hdl/xbar_bus_pkg.sv ====
// Request and response payload structs carried between masters, bridge and memory slaves
package xbar_bus_pkg;

    // Request payload, 69 bits. The request strobe travels separately
    typedef struct packed {
        xbar_cfg_pkg::addr_t addr;   // Target byte address
        logic                wen;    // 1 for load, 0 for store
        xbar_cfg_pkg::data_t wdata;  // Store data
        xbar_cfg_pkg::be_t   be;     // Byte enables
    } req_payload_t;

    // Response payload, 33 bits. Valid and ID travel separately
    typedef struct packed {
        xbar_cfg_pkg::data_t rdata;  // Load data
        logic                opc;    // Error flag from the slave
    } resp_payload_t;

endpackage

// ==== hdl/xbar_cfg_pkg.sv ====
// Bus widths and vector types shared by the crossbar bridge, referenced by scoped name
package xbar_cfg_pkg;

    // Address and data path widths
    localparam int ADDR_WIDTH = 32;
    localparam int DATA_WIDTH = 32;

    // One enable per data byte
    localparam int BE_WIDTH   = DATA_WIDTH / 8;

    // Byte address as seen by masters and slaves
    typedef logic [ADDR_WIDTH-1:0] addr_t;

    // Write data and read data word
    typedef logic [DATA_WIDTH-1:0] data_t;

    // Byte lane enables for stores
    typedef logic [BE_WIDTH-1:0]   be_t;

endpackage

// ==== testbench/tb_checker.sv ====
// Response checker for the bridge testbench that compares values and keeps the error counts
`timescale 1ns/1ns

module tb_checker
#(
    parameter int N_MASTER = 4,
    parameter int TIMEOUT  = 50
)
(
    input logic                                       clk,
    input logic [N_MASTER-1:0]                        r_valid_i,
    input xbar_bus_pkg::resp_payload_t [N_MASTER-1:0] r_payload_i
);

    int error_count = 0;
    int test_errors = 0;    // Errors inside the running test
    int test_count  = 0;
    int bad_tests   = 0;

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp)
        begin
            $display("CHECK FAILED %s: got 0x%08h, expected 0x%08h", name, got, exp);
            error_count++;
            test_errors++;
        end
    endtask

    task automatic fail(input string msg);
        $display("ERROR: %s", msg);
        error_count++;
        test_errors++;
    endtask

    // Next response must go to this master alone
    task automatic wait_resp(input int master, input xbar_cfg_pkg::data_t exp_rdata,
                             input logic exp_opc);
        int                  cnt;
        logic [N_MASTER-1:0] exp_valid;
        exp_valid         = '0;
        exp_valid[master] = 1'b1;
        cnt = 0;
        @(posedge clk);
        while (r_valid_i == '0 && cnt < TIMEOUT)
        begin
            @(posedge clk);
            cnt++;
        end
        if (r_valid_i == '0)
        begin
            fail($sformatf("no response reached master %0d in time", master));
        end
        else
        begin
            check_value("r_valid_o", 32'(r_valid_i), 32'(exp_valid));
            check_value("rdata", r_payload_i[master].rdata, exp_rdata);
            check_value("opc", 32'(r_payload_i[master].opc), 32'(exp_opc));
        end
    endtask

    task automatic test_done(input string name);
        test_count++;
        if (test_errors == 0)
        begin
            $display("ok   %s", name);
        end
        else
        begin
            $display("bad  %s (%0d errors)", name, test_errors);
            bad_tests++;
        end
        test_errors = 0;
    endtask

    task automatic print_counts();
        $display("Tests: %0d run, %0d failed, %0d errors", test_count, bad_tests, error_count);
    endtask

endmodule

// ==== testbench/tb_xbar_assertions.sv ====
// Protocol assertions for the bridge that are attached to every xbar_bridge instance by bind
`timescale 1ns/1ns

module tb_xbar_assertions
#(
    parameter int N_MASTER = 4,
    parameter int N_SLAVE  = 3
)
(
    input logic                             clk,
    input logic                             rst_i,
    input logic [N_SLAVE-1:0]               slv_req_i,
    input logic [N_SLAVE-1:0][N_MASTER-1:0] slv_id_i,
    input logic [N_SLAVE-1:0][N_MASTER-1:0] slv_mst_req_i,
    input logic [N_MASTER-1:0]              mst_gnt_i,
    input logic [N_MASTER-1:0]              mst_r_valid_i
);

    genvar s;

    generate
        for (s = 0; s < N_SLAVE; s++)
        begin : g_slave
            // The ID names exactly one master that addresses this slave
            a_id_onehot : assert property (@(posedge clk) disable iff (rst_i)
                slv_req_i[s] |-> $onehot(slv_id_i[s]) &&
                                 ((slv_id_i[s] & slv_mst_req_i[s]) != '0))
                else $error("id_o of slave %0d is not one requesting master", s);

            a_one_grant : assert property (@(posedge clk)
                $onehot0(mst_gnt_i & slv_mst_req_i[s]))   // Master side grants per slave
                else $error("slave %0d grants more than one master", s);
        end
    endgenerate

    a_reset_idle : assert property (@(posedge clk)
        rst_i |-> (slv_req_i == '0) && (mst_r_valid_i == '0))
        else $error("request or response active during reset");

endmodule

bind xbar_bridge tb_xbar_assertions
#(
    .N_MASTER ( N_MASTER ),
    .N_SLAVE  ( N_SLAVE  )
)
i_xbar_assertions
(
    .clk           ( clk         ),
    .rst_i         ( rst_i       ),
    .slv_req_i     ( req_o       ),
    .slv_id_i      ( id_o        ),
    .slv_mst_req_i ( slv_mst_req ),
    .mst_gnt_i     ( gnt_o       ),
    .mst_r_valid_i ( r_valid_o   )
);

// ==== testbench/tb_xbar_bridge.sv ====
// Testbench top for the bridge that runs a stimulus table and directed traffic against slave models
`timescale 1ns/1ns

module tb_xbar_bridge;

    localparam int N_MASTER = 4;
    localparam int N_SLAVE  = 3;
    localparam int N_ENTRY  = 2 * N_MASTER * N_SLAVE + 1;
    localparam int TIMEOUT  = 50;

    typedef struct packed {
        logic [1:0]          master;
        xbar_cfg_pkg::addr_t addr;
        logic                wen;
        xbar_cfg_pkg::data_t wdata;
        xbar_cfg_pkg::be_t   be;
        xbar_cfg_pkg::data_t exp_rdata;
        logic                exp_opc;
    } entry_t;

    logic clk;
    logic rst_i;
    logic [N_MASTER-1:0]                        req_i;
    xbar_bus_pkg::req_payload_t [N_MASTER-1:0]  payload_i;
    logic [N_MASTER-1:0]                        gnt_o;
    logic [N_MASTER-1:0]                        r_valid_o;
    xbar_bus_pkg::resp_payload_t [N_MASTER-1:0] r_payload_o;
    logic [N_SLAVE-1:0]                         req_o;
    xbar_bus_pkg::req_payload_t [N_SLAVE-1:0]   payload_o;
    logic [N_SLAVE-1:0][N_MASTER-1:0]           id_o;
    logic [N_SLAVE-1:0]                         gnt_i;
    logic [N_SLAVE-1:0]                         r_valid_i;
    logic [N_SLAVE-1:0][N_MASTER-1:0]           r_id_i;
    xbar_bus_pkg::resp_payload_t [N_SLAVE-1:0]  r_payload_i;
    xbar_cfg_pkg::addr_t [N_SLAVE-1:0]          start_addr;
    xbar_cfg_pkg::addr_t [N_SLAVE-1:0]          end_addr;

    integer seed = 32'h611df563;
    logic   rand_gnt;                                   // 0 forces every slave to grant

    entry_t              stim_table [N_ENTRY];
    xbar_cfg_pkg::data_t exp_word [N_MASTER][N_SLAVE];  // Word left behind by the table writes

    // Slave model state
    xbar_cfg_pkg::data_t         mem [N_SLAVE][16];
    logic [N_SLAVE-1:0]          acc_q;
    logic [N_MASTER-1:0]         acc_id [N_SLAVE];
    xbar_bus_pkg::resp_payload_t resp_q [N_SLAVE];
    logic [3:0]                  word_idx;

    xbar_bridge
    #(
        .N_MASTER ( N_MASTER ),
        .N_SLAVE  ( N_SLAVE  )
    )
    i_dut
    (
        .clk          ( clk         ),
        .rst_i        ( rst_i       ),
        .req_i        ( req_i       ),
        .payload_i    ( payload_i   ),
        .gnt_o        ( gnt_o       ),
        .r_valid_o    ( r_valid_o   ),
        .r_payload_o  ( r_payload_o ),
        .req_o        ( req_o       ),
        .payload_o    ( payload_o   ),
        .id_o         ( id_o        ),
        .gnt_i        ( gnt_i       ),
        .r_valid_i    ( r_valid_i   ),
        .r_id_i       ( r_id_i      ),
        .r_payload_i  ( r_payload_i ),
        .start_addr_i ( start_addr  ),
        .end_addr_i   ( end_addr    )
    );

    tb_checker
    #(
        .N_MASTER ( N_MASTER ),
        .TIMEOUT  ( TIMEOUT  )
    )
    i_checker
    (
        .clk         ( clk         ),
        .r_valid_i   ( r_valid_o   ),
        .r_payload_i ( r_payload_o )
    );

    initial
    begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // Initial memory content from the full byte address
    function automatic xbar_cfg_pkg::data_t fill_word(input xbar_cfg_pkg::addr_t a);
        return ~a ^ {a[15:0], a[31:16]};
    endfunction

    function automatic xbar_cfg_pkg::data_t merge_bytes(input xbar_cfg_pkg::data_t old_w,
                                                        input xbar_cfg_pkg::data_t new_w,
                                                        input xbar_cfg_pkg::be_t be);
        xbar_cfg_pkg::data_t res;
        res = old_w;
        for (int b = 0; b < xbar_cfg_pkg::BE_WIDTH; b++)
        begin
            if (be[b])
            begin
                res[8*b +: 8] = new_w[8*b +: 8];
            end
        end
        return res;
    endfunction

    // Accept on grant, access memory, answer on the next falling edge
    always @(posedge clk)
    begin
        for (int s = 0; s < N_SLAVE; s++)
        begin
            acc_q[s] = 1'b0;
            if (!rst_i && req_o[s] && gnt_i[s])
            begin
                word_idx        = payload_o[s].addr[5:2];
                acc_q[s]        = 1'b1;
                acc_id[s]       = id_o[s];
                resp_q[s].opc   = (payload_o[s].be == '0);   // Empty store is an error
                resp_q[s].rdata = payload_o[s].wen ? mem[s][word_idx] : '0;
                if (!payload_o[s].wen)
                begin
                    mem[s][word_idx] = merge_bytes(mem[s][word_idx], payload_o[s].wdata,
                                                   payload_o[s].be);
                end
            end
        end
    end

    always @(negedge clk)
    begin
        for (int s = 0; s < N_SLAVE; s++)
        begin
            gnt_i[s]       = rand_gnt ? 1'($random(seed)) : 1'b1;
            r_valid_i[s]   = acc_q[s];
            r_id_i[s]      = acc_id[s];
            r_payload_i[s] = resp_q[s];
        end
    end

    // Store then load per master and slave on a word of its own
    task automatic build_table();
        int                  n;
        int                  idx;
        xbar_cfg_pkg::addr_t a;
        xbar_cfg_pkg::data_t wd;
        xbar_cfg_pkg::be_t   be;
        n = 0;
        for (int m = 0; m < N_MASTER; m++)
        begin
            for (int s = 0; s < N_SLAVE; s++)
            begin
                idx = m * N_SLAVE + s;
                a   = start_addr[s] + xbar_cfg_pkg::addr_t'(idx * 4);
                wd  = $random(seed);
                be  = xbar_cfg_pkg::be_t'(idx % 15 + 1);
                exp_word[m][s] = merge_bytes(fill_word(a), wd, be);
                stim_table[n]     = '{2'(m), a, 1'b0, wd, be, '0, 1'b0};
                stim_table[n + 1] = '{2'(m), a, 1'b1, '0, '1, exp_word[m][s], 1'b0};
                n = n + 2;
            end
        end
        // Zero byte enables come back with the error flag
        stim_table[n] = '{2'd2, start_addr[1] + 32'h3c, 1'b0, 32'hdead_beef, '0, '0, 1'b1};
    endtask

    task automatic apply_entry(input entry_t e, input int num);
        int cnt;
        @(negedge clk);
        req_i[e.master]     = 1'b1;
        payload_i[e.master] = '{e.addr, e.wen, e.wdata, e.be};
        cnt = 0;
        @(posedge clk);
        while (!gnt_o[e.master] && cnt < TIMEOUT)
        begin
            @(posedge clk);
            cnt++;
        end
        if (!gnt_o[e.master])
        begin
            i_checker.fail($sformatf("master %0d was never granted", e.master));
        end
        @(negedge clk);
        req_i[e.master]     = 1'b0;
        payload_i[e.master] = '0;
        i_checker.wait_resp(int'(e.master), e.exp_rdata, e.exp_opc);
        i_checker.test_done($sformatf("table entry %0d", num));
    endtask

    task automatic reset_dut();
        @(negedge clk);
        rst_i = 1'b1;
        repeat (5) @(negedge clk);
        rst_i = 1'b0;
    endtask

    // All masters on slave 0 with grants and responses in order 0..3
    task automatic same_slave_test();
        int                  grant_next;
        int                  resp_next;
        int                  cnt;
        logic [N_MASTER-1:0] drop;
        reset_dut();
        @(negedge clk);
        for (int m = 0; m < N_MASTER; m++)
        begin
            req_i[m]     = 1'b1;
            payload_i[m] = '{start_addr[0] + xbar_cfg_pkg::addr_t'(m * N_SLAVE * 4),
                             1'b1, '0, '1};
        end
        grant_next = 0;
        resp_next  = 0;
        cnt        = 0;
        while ((grant_next < N_MASTER || resp_next < N_MASTER) && cnt < 4 * TIMEOUT)
        begin
            @(posedge clk);
            cnt++;
            drop = gnt_o;
            if (gnt_o != '0)
            begin
                i_checker.check_value("gnt_o", 32'(gnt_o), 32'(1) << grant_next);
                grant_next++;
            end
            if (r_valid_o != '0 && resp_next < N_MASTER)
            begin
                i_checker.check_value("r_valid_o", 32'(r_valid_o), 32'(1) << resp_next);
                i_checker.check_value("rdata", r_payload_o[resp_next].rdata,
                                      exp_word[resp_next][0]);
                resp_next++;
            end
            @(negedge clk);
            req_i = req_i & ~drop;
        end
        if (resp_next < N_MASTER)
        begin
            i_checker.fail("shared slave test did not complete in time");
        end
        req_i     = '0;
        payload_i = '0;
        i_checker.test_done("all masters to one slave");
    endtask

    // Master m to slave m with every slave granting
    task automatic parallel_test();
        int cnt;
        rand_gnt = 1'b0;
        @(negedge clk);
        @(negedge clk);
        for (int m = 0; m < N_SLAVE; m++)
        begin
            req_i[m]     = 1'b1;
            payload_i[m] = '{start_addr[m] + xbar_cfg_pkg::addr_t'((m * N_SLAVE + m) * 4),
                             1'b1, '0, '1};
        end
        @(posedge clk);
        i_checker.check_value("gnt_o", 32'(gnt_o), 32'h7);
        @(negedge clk);
        req_i     = '0;
        payload_i = '0;
        cnt = 0;
        @(posedge clk);
        while (r_valid_o == '0 && cnt < TIMEOUT)
        begin
            @(posedge clk);
            cnt++;
        end
        i_checker.check_value("r_valid_o", 32'(r_valid_o), 32'h7);
        for (int m = 0; m < N_SLAVE; m++)
        begin
            i_checker.check_value("rdata", r_payload_o[m].rdata, exp_word[m][m]);
        end
        rand_gnt = 1'b1;
        i_checker.test_done("parallel masters to different slaves");
    endtask

    task automatic unmapped_test();
        @(negedge clk);
        req_i[3]     = 1'b1;
        payload_i[3] = '{32'h2000_0000, 1'b1, '0, '1};
        repeat (10)
        begin
            @(posedge clk);
            i_checker.check_value("req_o", 32'(req_o), 32'h0);
            i_checker.check_value("gnt_o", 32'(gnt_o), 32'h0);
        end
        @(negedge clk);
        req_i     = '0;                                 // Withdraw the request
        payload_i = '0;
        i_checker.test_done("unmapped address");
    endtask

    initial
    begin
        rst_i       = 1'b1;
        rand_gnt    = 1'b1;
        req_i       = '0;
        payload_i   = '0;
        gnt_i       = '0;
        r_valid_i   = '0;
        r_id_i      = '0;
        r_payload_i = '0;
        acc_q       = '0;
        for (int s = 0; s < N_SLAVE; s++)
        begin
            acc_id[s] = '0;
            resp_q[s] = '0;
        end
        start_addr[0] = 32'h0000_0000;
        end_addr[0]   = 32'h0000_1000;
        start_addr[1] = 32'h0010_0000;
        end_addr[1]   = 32'h0010_1000;
        start_addr[2] = 32'h1000_0000;
        end_addr[2]   = 32'h1000_1000;
        for (int s = 0; s < N_SLAVE; s++)
        begin
            for (int i = 0; i < 16; i++)
            begin
                mem[s][i] = fill_word(start_addr[s] + xbar_cfg_pkg::addr_t'(i * 4));
            end
        end
        build_table();
        repeat (5) @(negedge clk);
        rst_i = 1'b0;

        // Idle after reset
        repeat (5)
        begin
            @(posedge clk);
            i_checker.check_value("req_o", 32'(req_o), 32'h0);
            i_checker.check_value("r_valid_o", 32'(r_valid_o), 32'h0);
        end
        i_checker.test_done("idle after reset");

        for (int i = 0; i < N_ENTRY; i++)
        begin
            apply_entry(stim_table[i], i);
        end
        same_slave_test();
        parallel_test();
        unmapped_test();

        i_checker.print_counts();
        if (i_checker.error_count == 0)
        begin
            $display("TEST PASS");
        end
        else
        begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule
